//--- sources.f
ip_pkg.sv
ip_rx_parser.sv
ip_rx_adapter.sv
byte_fifo.sv
ip_rx_top.sv
ip_rx_props.sv
tb_ip_rx.sv

//--- Bender.yml
package:
  name: ip_rx

sources:
  - ip_pkg.sv
  - ip_rx_parser.sv
  - ip_rx_adapter.sv
  - byte_fifo.sv
  - ip_rx_top.sv
  - target: simulation
    files:
      - ip_rx_props.sv
      - tb_ip_rx.sv

//--- tb_ip_rx.sv
`timescale 1ns/1ps

module tb_ip_rx;
  import ip_pkg::*;

  localparam logic [31:0] SEED     = 32'h914d_0b86;
  localparam int          WAIT_MAX = 5000;  // Cycles allowed for any single wait

  logic        i_clk;
  logic        i_rst_n;
  logic        i_s_tvalid;
  ip_byte_t    i_s_tdata;
  logic        i_s_tlast;
  logic        o_s_tready;
  logic        i_enable;
  logic        i_m_rd;
  fifo_entry_t o_m_entry;
  logic        o_m_empty_n;
  ip_word_t    o_drop_count;

  logic [31:0] stim_lfsr;
  logic [31:0] read_lfsr;
  logic [31:0] read_bits;
  logic        hold_reads;
  fifo_entry_t exp_q[$];    // Entries the FIFO still owes
  ip_word_t    exp_drops;

  ip_rx_top dut0 (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_s_tvalid   (i_s_tvalid),
    .i_s_tdata    (i_s_tdata),
    .i_s_tlast    (i_s_tlast),
    .o_s_tready   (o_s_tready),
    .i_enable     (i_enable),
    .i_m_rd       (i_m_rd),
    .o_m_entry    (o_m_entry),
    .o_m_empty_n  (o_m_empty_n),
    .o_drop_count (o_drop_count)
  );

  bind ip_rx_top ip_rx_props props0 (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_wr_en       (wr_en),
    .i_full_n      (full_n),
    .i_hdr_valid   (hdr_valid),
    .i_hdr_ready   (hdr_ready),
    .i_empty_n     (o_m_empty_n),
    .i_wr_ptr      (fifo0.wr_ptr),
    .i_rd_ptr      (fifo0.rd_ptr),
    .i_parse_state (parser0.state),
    .i_s_tvalid    (i_s_tvalid),
    .i_s_tlast     (i_s_tlast),
    .i_s_tready    (o_s_tready)
  );

  initial i_clk = 1'b0;
  always #10 i_clk = ~i_clk;

  // Taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      st = lfsr_next(st);
      v  = {v[30:0], st[0]};
    end
  endtask

  // One's-complement sum of the ten header words
  function automatic ip_word_t header_sum(input ip_hdr_t h);
    logic [16:0] acc;
    acc = '0;
    for (int i = 0; i < 10; i++) begin
      acc = acc[15:0] + h[159-16*i -: 16];
      acc = acc[15:0] + acc[16];  // End-around carry
    end
    return acc[15:0];
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic entry_check(input string name, input fifo_entry_t got, input fifo_entry_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      abort_run("FIFO entry mismatch");
    end
  endtask

  task automatic count_check(input string name, input ip_word_t got, input ip_word_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      abort_run("counter mismatch");
    end
  endtask

  task automatic flag_check(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
      abort_run("status flag mismatch");
    end
  endtask

  // Returns on the rising edge that takes the byte
  task automatic drive_byte(input ip_byte_t b, input logic last);
    int n;
    i_s_tvalid <= 1'b1;
    i_s_tdata  <= b;
    i_s_tlast  <= last;
    n = 0;
    @(posedge i_clk);
    while (!o_s_tready) begin
      n++;
      if (n > WAIT_MAX) abort_run("input byte was never accepted by o_s_tready");
      @(posedge i_clk);
    end
  endtask

  task automatic send_datagram(input bit allow_bad, input bit gaps);
    ip_hdr_t     h;
    logic [31:0] v;
    int          plen;
    ip_byte_t    bytes[$];
    fifo_entry_t e;
    bit          good;
    take_bits(stim_lfsr, 6, v);
    plen = (v % 40) + 1;
    take_bits(stim_lfsr, 24, v);
    {h.dscp, h.ecn, h.ttl, h.protocol} = v[23:0];
    take_bits(stim_lfsr, 32, v);
    {h.identification, h.flags, h.frag_offset} = v;
    take_bits(stim_lfsr, 32, v);
    h.src_addr = v;
    take_bits(stim_lfsr, 32, v);
    h.dst_addr = v;
    h.version  = 4'd4;
    h.ihl      = IP_IHL_MIN;
    h.length   = 16'(20 + plen);
    h.checksum = '0;
    take_bits(stim_lfsr, 3, v);
    if (allow_bad && v[2:0] == 3'd7) begin
      h.ihl = 4'd6;  // IHL of 6 with a valid checksum
    end
    h.checksum = ~header_sum(h);
    if (allow_bad && v[1:0] == 2'd0) begin
      take_bits(stim_lfsr, 15, v);
      h.checksum ^= {1'b0, v[14:0] | 15'd1};
    end
    good = (header_sum(h) == 16'hFFFF) && (h.ihl == IP_IHL_MIN);
    for (int i = 0; i < 20; i++) begin
      bytes.push_back(h[159-8*i -: 8]);
    end
    for (int i = 0; i < plen; i++) begin
      take_bits(stim_lfsr, 8, v);
      bytes.push_back(v[7:0]);
    end
    if (good) begin
      foreach (bytes[i]) begin
        e.last = (i == bytes.size() - 1);
        e.data = bytes[i];
        exp_q.push_back(e);
      end
    end else begin
      exp_drops++;
    end
    foreach (bytes[i]) begin
      if (gaps) begin
        take_bits(stim_lfsr, 2, v);
        if (v[1:0] == 2'd0) begin
          i_s_tvalid <= 1'b0;
          take_bits(stim_lfsr, 2, v);
          repeat (v[1:0] + 1) @(posedge i_clk);
        end
      end
      drive_byte(bytes[i], i == bytes.size() - 1);
    end
  endtask

  task automatic drain_and_check();
    int n;
    i_s_tvalid <= 1'b0;
    n = 0;
    @(posedge i_clk);
    while (exp_q.size() != 0 || o_m_empty_n) begin
      n++;
      if (n > WAIT_MAX) abort_run("FIFO did not drain, expected entries never came out");
      @(posedge i_clk);
    end
    count_check("o_drop_count", o_drop_count, exp_drops);
  endtask

  // Releases reads once the input has been held off for a long stretch
  task automatic wait_for_stall();
    int n;
    int run;
    n   = 0;
    run = 0;
    while (run < 40) begin
      @(posedge i_clk);
      run = (i_s_tvalid && !o_s_tready) ? run + 1 : 0;
      n++;
      if (n > WAIT_MAX) abort_run("o_s_tready never stayed low with reads held off");
    end
    hold_reads <= 1'b0;
  endtask

  always @(posedge i_clk) begin
    if (!i_rst_n || hold_reads) begin
      i_m_rd <= 1'b0;
    end else begin
      take_bits(read_lfsr, 2, read_bits);
      i_m_rd <= (read_bits[1:0] != 2'd0);  // Three cycles in four
    end
  end

  // Head entry is sampled half a cycle before its pop
  always @(negedge i_clk) begin
    if (i_rst_n && i_m_rd && o_m_empty_n) begin
      if (exp_q.size() == 0) begin
        abort_run("FIFO delivered an entry that no good datagram produced");
      end else begin
        entry_check("o_m_entry", o_m_entry, exp_q.pop_front());
      end
    end
    if (dut0.props0.fail_count != 0) begin
      abort_run("a bound assertion in ip_rx_props failed");
    end
  end

  initial begin
    stim_lfsr  = SEED;
    read_lfsr  = SEED;
    exp_drops  = '0;
    hold_reads = 1'b0;
    i_rst_n    = 1'b0;
    i_s_tvalid = 1'b0;
    i_s_tdata  = '0;
    i_s_tlast  = 1'b0;
    i_enable   = 1'b1;
    i_m_rd     = 1'b0;
    repeat (5) @(posedge i_clk);
    i_rst_n <= 1'b1;
    @(negedge i_clk);
    flag_check("o_m_empty_n", o_m_empty_n, 1'b0);
    flag_check("o_s_tready", o_s_tready, 1'b1);
    count_check("o_drop_count", o_drop_count, 16'd0);
    @(posedge i_clk);

    // Random mix of good and bad datagrams with input gaps
    repeat (20) send_datagram(1'b1, 1'b1);
    drain_and_check();

    // Back to back
    repeat (12) send_datagram(1'b1, 1'b0);
    drain_and_check();

    hold_reads <= 1'b1;
    fork
      repeat (3) send_datagram(1'b0, 1'b0);
      wait_for_stall();
    join
    drain_and_check();

    i_enable <= 1'b0;
    fork
      send_datagram(1'b0, 1'b1);
      begin
        repeat (60) begin
          @(negedge i_clk);
          flag_check("o_m_empty_n", o_m_empty_n, 1'b0);
        end
        @(posedge i_clk);
        i_enable <= 1'b1;
      end
    join
    drain_and_check();

    @(negedge i_clk);
    if (dut0.props0.fail_count != 0) begin
      abort_run("a bound assertion in ip_rx_props failed");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

//--- ip_rx_props.sv
`timescale 1ns/1ps

module ip_rx_props
  import ip_pkg::*;
(
  input logic                     i_clk,
  input logic                     i_rst_n,
  input logic                     i_wr_en,
  input logic                     i_full_n,
  input logic                     i_hdr_valid,
  input logic                     i_hdr_ready,
  input logic                     i_empty_n,
  input logic [FIFO_DEPTH_LOG2:0] i_wr_ptr,
  input logic [FIFO_DEPTH_LOG2:0] i_rd_ptr,
  input rx_parse_state_t          i_parse_state,
  input logic                     i_s_tvalid,
  input logic                     i_s_tlast,
  input logic                     i_s_tready
);

  int fail_count = 0;

  a_no_write_when_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_wr_en |-> i_full_n)
    else begin
      $error("write strobe high while FIFO full");
      fail_count++;
    end

  a_hdr_valid_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_hdr_valid && !i_hdr_ready |=> i_hdr_valid)
    else begin
      $error("header valid dropped before transfer");
      fail_count++;
    end

  // Pointers that met stay met until a write, a read on empty moves nothing
  a_empty_on_equal_ptrs: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_wr_ptr == i_rd_ptr) && !i_wr_en |=> !i_empty_n)
    else begin
      $error("empty_n high with no entry written");
      fail_count++;
    end

  a_ready_in_hdr: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_s_tvalid && i_s_tready && i_s_tlast |=> (i_parse_state == PS_HDR) && i_s_tready)
    else begin
      $error("input ready low while parser collects header");
      fail_count++;
    end

endmodule

//--- ip_rx_top.sv
`timescale 1ns/1ps

module ip_rx_top
  import ip_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_rst_n,
  input  logic        i_s_tvalid,
  input  ip_byte_t    i_s_tdata,
  input  logic        i_s_tlast,
  output logic        o_s_tready,
  input  logic        i_enable,
  input  logic        i_m_rd,
  output fifo_entry_t o_m_entry,
  output logic        o_m_empty_n,
  output ip_word_t    o_drop_count
);

  ip_hdr_t     hdr;
  logic        hdr_valid;
  logic        hdr_ready;
  ip_byte_t    pay_data;
  logic        pay_last;
  logic        pay_valid;
  logic        pay_ready;
  logic        wr_en;
  fifo_entry_t wr_entry;
  logic        full_n;

  ip_rx_parser parser0 (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_s_tvalid   (i_s_tvalid),
    .i_s_tdata    (i_s_tdata),
    .i_s_tlast    (i_s_tlast),
    .o_s_tready   (o_s_tready),
    .o_hdr        (hdr),
    .o_hdr_valid  (hdr_valid),
    .i_hdr_ready  (hdr_ready),
    .o_pay_data   (pay_data),
    .o_pay_last   (pay_last),
    .o_pay_valid  (pay_valid),
    .i_pay_ready  (pay_ready),
    .o_drop_count (o_drop_count)
  );

  ip_rx_adapter adapter0 (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_enable    (i_enable),
    .i_hdr       (hdr),
    .i_hdr_valid (hdr_valid),
    .o_hdr_ready (hdr_ready),
    .i_pay_data  (pay_data),
    .i_pay_last  (pay_last),
    .i_pay_valid (pay_valid),
    .o_pay_ready (pay_ready),
    .o_wr_en     (wr_en),
    .o_wr_entry  (wr_entry),
    .i_full_n    (full_n)
  );

  byte_fifo #(
    .DEPTH_LOG2 (FIFO_DEPTH_LOG2)
  ) fifo0 (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_wr_en    (wr_en),
    .i_wr_entry (wr_entry),
    .o_full_n   (full_n),
    .i_rd       (i_m_rd),
    .o_rd_entry (o_m_entry),
    .o_empty_n  (o_m_empty_n)
  );

endmodule

//--- byte_fifo.sv
`timescale 1ns/1ps

module byte_fifo
  import ip_pkg::*;
#(
  parameter int DEPTH_LOG2 = FIFO_DEPTH_LOG2
) (
  input  logic        i_clk,
  input  logic        i_rst_n,
  input  logic        i_wr_en,
  input  fifo_entry_t i_wr_entry,
  output logic        o_full_n,
  input  logic        i_rd,
  output fifo_entry_t o_rd_entry,
  output logic        o_empty_n
);

  localparam int DEPTH = 2 ** DEPTH_LOG2;

  fifo_entry_t mem [DEPTH];

  // Extra top bit tells full from empty
  logic [DEPTH_LOG2:0] wr_ptr;
  logic [DEPTH_LOG2:0] rd_ptr;

  logic do_wr;
  logic do_rd;

  assign o_empty_n = (wr_ptr != rd_ptr);
  assign o_full_n  = !((wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) &&
                       (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]));

  assign do_wr = i_wr_en && o_full_n;
  assign do_rd = i_rd && o_empty_n;  // Read on empty is ignored

  always_ff @(posedge i_clk) begin
    if (do_wr) begin
      mem[wr_ptr[DEPTH_LOG2-1:0]] <= i_wr_entry;
    end
  end

  assign o_rd_entry = mem[rd_ptr[DEPTH_LOG2-1:0]];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

//--- ip_rx_adapter.sv
`timescale 1ns/1ps

module ip_rx_adapter
  import ip_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_rst_n,
  input  logic        i_enable,
  input  ip_hdr_t     i_hdr,
  input  logic        i_hdr_valid,
  output logic        o_hdr_ready,
  input  ip_byte_t    i_pay_data,
  input  logic        i_pay_last,
  input  logic        i_pay_valid,
  output logic        o_pay_ready,
  output logic        o_wr_en,
  output fifo_entry_t o_wr_entry,
  input  logic        i_full_n
);

  rx_adapt_state_t state;
  hdr_off_t        offset;  // Next header byte to write
  ip_hdr_t         hdr_q;
  ip_byte_t        hdr_byte;

  always_comb begin
    case (offset)
      IP_HDR_OFF_VER_IHL:         hdr_byte = {hdr_q.version, hdr_q.ihl};
      IP_HDR_OFF_TOS:             hdr_byte = {hdr_q.dscp, hdr_q.ecn};
      IP_HDR_OFF_TOT_LEN:         hdr_byte = hdr_q.length[15:8];
      IP_HDR_OFF_TOT_LEN + 5'd1:  hdr_byte = hdr_q.length[7:0];
      IP_HDR_OFF_ID:              hdr_byte = hdr_q.identification[15:8];
      IP_HDR_OFF_ID + 5'd1:       hdr_byte = hdr_q.identification[7:0];
      IP_HDR_OFF_FLAG_OFF:        hdr_byte = {hdr_q.flags, hdr_q.frag_offset[12:8]};
      IP_HDR_OFF_FLAG_OFF + 5'd1: hdr_byte = hdr_q.frag_offset[7:0];
      IP_HDR_OFF_TTL:             hdr_byte = hdr_q.ttl;
      IP_HDR_OFF_PROTOCOL:        hdr_byte = hdr_q.protocol;
      IP_HDR_OFF_CHECK:           hdr_byte = hdr_q.checksum[15:8];
      IP_HDR_OFF_CHECK + 5'd1:    hdr_byte = hdr_q.checksum[7:0];
      IP_HDR_OFF_SADDR:           hdr_byte = hdr_q.src_addr[31:24];
      IP_HDR_OFF_SADDR + 5'd1:    hdr_byte = hdr_q.src_addr[23:16];
      IP_HDR_OFF_SADDR + 5'd2:    hdr_byte = hdr_q.src_addr[15:8];
      IP_HDR_OFF_SADDR + 5'd3:    hdr_byte = hdr_q.src_addr[7:0];
      IP_HDR_OFF_DADDR:           hdr_byte = hdr_q.dst_addr[31:24];
      IP_HDR_OFF_DADDR + 5'd1:    hdr_byte = hdr_q.dst_addr[23:16];
      IP_HDR_OFF_DADDR + 5'd2:    hdr_byte = hdr_q.dst_addr[15:8];
      IP_HDR_OFF_DADDR + 5'd3:    hdr_byte = hdr_q.dst_addr[7:0];
      default:                    hdr_byte = '0;
    endcase
  end

  // Nothing moves while disabled
  assign o_hdr_ready = i_enable && (state == AS_WAIT_HDR);
  assign o_pay_ready = i_enable && (state == AS_PAYLOAD) && i_full_n;

  always_comb begin
    o_wr_en = 1'b0;
    o_wr_entry.last = 1'b0;  // Header bytes never end a datagram
    o_wr_entry.data = hdr_byte;
    if (i_enable && i_full_n) begin
      if (state == AS_WRITE_HDR) begin
        o_wr_en = 1'b1;
      end else if (state == AS_PAYLOAD) begin
        o_wr_en = i_pay_valid;
      end
    end
    if (state == AS_PAYLOAD) begin
      o_wr_entry.last = i_pay_last;
      o_wr_entry.data = i_pay_data;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_hdr_valid && o_hdr_ready) begin
      hdr_q <= i_hdr;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state  <= AS_WAIT_HDR;
      offset <= '0;
    end else if (!i_enable) begin
      state  <= AS_WAIT_HDR;
      offset <= '0;
    end else begin
      case (state)
        AS_WAIT_HDR: begin
          if (i_hdr_valid) begin
            offset <= '0;
            state  <= AS_WRITE_HDR;
          end
        end
        AS_WRITE_HDR: begin
          if (i_full_n) begin
            if (offset == IP_HDR_SIZE - 5'd1) begin
              offset <= '0;
              state  <= AS_PAYLOAD;
            end else begin
              offset <= offset + 5'd1;
            end
          end
        end
        AS_PAYLOAD: begin
          if (i_pay_valid && o_pay_ready && i_pay_last) begin
            state <= AS_WAIT_HDR;
          end
        end
        default: state <= AS_WAIT_HDR;
      endcase
    end
  end

endmodule

//--- ip_rx_parser.sv
`timescale 1ns/1ps

module ip_rx_parser
  import ip_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_rst_n,
  input  logic     i_s_tvalid,
  input  ip_byte_t i_s_tdata,
  input  logic     i_s_tlast,
  output logic     o_s_tready,
  output ip_hdr_t  o_hdr,
  output logic     o_hdr_valid,
  input  logic     i_hdr_ready,
  output ip_byte_t o_pay_data,
  output logic     o_pay_last,
  output logic     o_pay_valid,
  input  logic     i_pay_ready,
  output ip_word_t o_drop_count
);

  rx_parse_state_t state;
  hdr_off_t        hdr_cnt;    // Header bytes taken so far
  ip_hdr_t         hdr_q;
  ip_word_t        csum;       // Running one's-complement sum
  ip_word_t        drop_count;

  ip_hdr_t     hdr_nxt;
  logic [16:0] sum_raw;
  ip_word_t    csum_nxt;
  logic        take_byte;
  logic        hdr_done;
  logic        hdr_good;

  always_comb begin
    hdr_nxt   = {hdr_q[$bits(ip_hdr_t)-9:0], i_s_tdata};
    // Previous byte is still in the low bits of hdr_q, forming the word
    sum_raw   = {1'b0, csum} + {1'b0, hdr_q[7:0], i_s_tdata};
    csum_nxt  = hdr_cnt[0] ? sum_raw[15:0] + {15'd0, sum_raw[16]} : csum;
    take_byte = (state == PS_HDR) && i_s_tvalid;
    hdr_done  = take_byte && (hdr_cnt == IP_HDR_SIZE - 5'd1);
    hdr_good  = (csum_nxt == 16'hFFFF) && (hdr_nxt.ihl == IP_IHL_MIN);
  end

  // Header shift register holds its value through PRESENT
  always_ff @(posedge i_clk) begin
    if (take_byte) begin
      hdr_q <= hdr_nxt;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state      <= PS_HDR;
      hdr_cnt    <= '0;
      csum       <= '0;
      drop_count <= '0;
    end else begin
      case (state)
        PS_HDR: begin
          if (take_byte) begin
            if (i_s_tlast) begin
              // Runt datagram, nothing left to forward
              hdr_cnt    <= '0;
              csum       <= '0;
              drop_count <= drop_count + 16'd1;
            end else if (hdr_done) begin
              hdr_cnt <= '0;
              csum    <= '0;
              state   <= hdr_good ? PS_PRESENT : PS_DROP;
            end else begin
              hdr_cnt <= hdr_cnt + 5'd1;
              csum    <= csum_nxt;
            end
          end
        end
        PS_PRESENT: begin
          if (i_hdr_ready) begin
            state <= PS_PAYLOAD;
          end
        end
        PS_PAYLOAD: begin
          if (i_s_tvalid && i_pay_ready && i_s_tlast) begin
            state <= PS_HDR;
          end
        end
        PS_DROP: begin
          if (i_s_tvalid && i_s_tlast) begin
            drop_count <= drop_count + 16'd1;
            state      <= PS_HDR;
          end
        end
        default: state <= PS_HDR;
      endcase
    end
  end

  always_comb begin
    case (state)
      PS_HDR:     o_s_tready = 1'b1;
      PS_PAYLOAD: o_s_tready = i_pay_ready;
      PS_DROP:    o_s_tready = 1'b1;  // Discard at full rate
      default:    o_s_tready = 1'b0;
    endcase
  end

  assign o_hdr        = hdr_q;
  assign o_hdr_valid  = (state == PS_PRESENT);
  assign o_pay_data   = i_s_tdata;
  assign o_pay_last   = i_s_tlast;
  assign o_pay_valid  = (state == PS_PAYLOAD) && i_s_tvalid;
  assign o_drop_count = drop_count;

endmodule

//--- ip_pkg.sv
package ip_pkg;

  typedef logic [7:0]  ip_byte_t;   // One stream byte
  typedef logic [15:0] ip_word_t;   // Length, identification, checksum
  typedef logic [31:0] ip_addr_t;   // IPv4 address
  typedef logic [4:0]  hdr_off_t;   // Byte position inside the header

  // Fields in wire order, so the first header byte sits in the top bits
  typedef struct packed {
    logic [3:0]  version;
    logic [3:0]  ihl;
    logic [5:0]  dscp;
    logic [1:0]  ecn;
    ip_word_t    length;
    ip_word_t    identification;
    logic [2:0]  flags;
    logic [12:0] frag_offset;
    ip_byte_t    ttl;
    ip_byte_t    protocol;
    ip_word_t    checksum;
    ip_addr_t    src_addr;
    ip_addr_t    dst_addr;
  } ip_hdr_t;

  typedef struct packed {
    logic     last;  // Final byte of the datagram
    ip_byte_t data;
  } fifo_entry_t;

  localparam hdr_off_t IP_HDR_SIZE = 5'd20;

  // Header byte offsets
  localparam hdr_off_t IP_HDR_OFF_VER_IHL  = 5'd0;
  localparam hdr_off_t IP_HDR_OFF_TOS      = 5'd1;
  localparam hdr_off_t IP_HDR_OFF_TOT_LEN  = 5'd2;
  localparam hdr_off_t IP_HDR_OFF_ID       = 5'd4;
  localparam hdr_off_t IP_HDR_OFF_FLAG_OFF = 5'd6;
  localparam hdr_off_t IP_HDR_OFF_TTL      = 5'd8;
  localparam hdr_off_t IP_HDR_OFF_PROTOCOL = 5'd9;
  localparam hdr_off_t IP_HDR_OFF_CHECK    = 5'd10;
  localparam hdr_off_t IP_HDR_OFF_SADDR    = 5'd12;
  localparam hdr_off_t IP_HDR_OFF_DADDR    = 5'd16;

  localparam logic [3:0] IP_IHL_MIN = 4'd5;  // No options supported

  localparam int FIFO_DEPTH_LOG2 = 5;

  typedef enum logic [1:0] {
    PS_HDR,
    PS_PRESENT,
    PS_PAYLOAD,
    PS_DROP
  } rx_parse_state_t;

  typedef enum logic [1:0] {
    AS_WAIT_HDR,
    AS_WRITE_HDR,
    AS_PAYLOAD
  } rx_adapt_state_t;

endpackage
